// File: src/cpu_pkg.sv
package cpu_pkg;

  typedef logic [7:0] word_t;     // Data byte
  typedef logic [13:0] addr_t;    // Program address
  typedef logic [2:0] reg_sel_t;  // A, B, C, D, E, H, L, M
  typedef logic [2:0] sp_t;       // Address stack pointer

  localparam int stack_depth = 8;
  localparam int num_regs = 7;

  localparam reg_sel_t reg_acc = 3'd0;
  localparam reg_sel_t reg_mem = 3'd7;  // M, no memory operands in this core

  // Bit 0 is carry so instruction bits 4:3 index the flag directly
  typedef struct packed {
    logic parity;  // Set on even number of ones
    logic sign;
    logic zero;
    logic carry;
  } flags_t;

  typedef enum logic [2:0] {T1, T2, T3, T4, T5, STOPPED} state_t;

  typedef enum logic [1:0] {CYCLE1, CYCLE2, CYCLE3} cycle_t;

  // Sent in bits 7:6 during T2
  typedef enum logic [1:0] {
    PCI = 2'b00,  // Instruction fetch
    PCC = 2'b01,  // Command, used by OUT
    PCR = 2'b10   // Data read
  } cycle_type_t;

  typedef enum logic [2:0] {ADD, ADC, SUB, SBB, ANA, XRA, ORA, CMP} alu_op_t;

  typedef enum logic [1:0] {RLC, RRC, RAL, RAR} rot_op_t;

  typedef enum logic [2:0] {NONE, PC_LO, PC_HI, REG, ALU, TMP_A, TMP_B, DATA_IN} bus_src_t;

  typedef struct packed {
    bus_src_t bus_src;
    cycle_type_t cycle_type;
    logic ir_we;
    logic a_we;
    logic a_from_acc;  // A takes the accumulator instead of the bus
    logic b_we;
    logic rf_we;
    reg_sel_t rf_sel;
    logic alu_en;      // One of the eight ALU operations
    logic alu_is_rot;
    alu_op_t alu_op;
    rot_op_t rot_op;
    logic flag_we;
    logic pc_inc;
    logic stack_we_lo;
    logic stack_we_hi;
    logic sp_push;
    logic sp_pop;
  } ctrl_t;

  typedef struct packed {
    word_t data;
    state_t state;
    logic sync;
  } bus_out_t;

  // Opcode patterns with their operand fields cleared
  localparam word_t op_mov = 8'b11_000_000;  // 11 DDD SSS
  localparam word_t op_alu_r = 8'b10_000_000;  // 10 PPP SSS
  localparam word_t op_mvi = 8'b00_000_110;  // 00 DDD 110
  localparam word_t op_inr = 8'b00_000_000;  // 00 DDD 000
  localparam word_t op_dcr = 8'b00_000_001;  // 00 DDD 001
  localparam word_t op_alu_i = 8'b00_000_100;  // 00 PPP 100
  localparam word_t op_rot = 8'b00_000_010;  // 00 0RR 010
  localparam word_t op_ret = 8'b00_000_111;  // 00 XXX 111
  localparam word_t op_jmp = 8'b01_000_100;  // 01 XXX 100
  localparam word_t op_cal = 8'b01_000_110;  // 01 XXX 110
  localparam word_t op_jfc = 8'b01_000_000;  // 01 0CC 000
  localparam word_t op_jtc = 8'b01_100_000;  // 01 1CC 000
  localparam word_t op_out = 8'b01_000_001;  // 01 RRM MM1, RR not 00
  localparam word_t op_hlt = 8'b00_000_000;  // Also 00 000 001
  localparam word_t op_hlt_alt = 8'b11_111_111;

  // Masks that keep the fixed opcode bits
  localparam word_t mask_two_fields = 8'b11_000_000;
  localparam word_t mask_dst_field = 8'b11_000_111;
  localparam word_t mask_cc_field = 8'b11_100_111;
  localparam word_t mask_out = 8'b11_000_001;
  localparam word_t mask_hlt = 8'b11_111_110;

endpackage

// File: src/alu.sv
module alu (
  input  logic clk,
  input  logic rst,
  input  cpu_pkg::word_t a,
  input  cpu_pkg::word_t b,
  input  cpu_pkg::alu_op_t op,
  input  cpu_pkg::rot_op_t rot_op,
  input  logic is_rot,
  input  logic is_incdec,
  input  logic is_dec,
  input  logic flag_we,
  output cpu_pkg::word_t result,
  output cpu_pkg::flags_t flags
);

  logic [8:0] wide;  // Carry or borrow in bit 8
  cpu_pkg::word_t chk;
  logic cy;
  cpu_pkg::flags_t flags_next;

  always_comb begin
    wide = '0;
    result = a;
    cy = flags.carry;  // INR and DCR keep it
    if (is_rot) begin
      case (rot_op)
        cpu_pkg::RLC: {cy, result} = {a[7], a[6:0], a[7]};
        cpu_pkg::RRC: {cy, result} = {a[0], a[0], a[7:1]};
        cpu_pkg::RAL: {cy, result} = {a[7], a[6:0], flags.carry};
        default:      {cy, result} = {a[0], flags.carry, a[7:1]};
      endcase
    end else if (is_incdec) begin
      result = is_dec ? a - 8'd1 : a + 8'd1;
    end else begin
      case (op)
        cpu_pkg::ADD: wide = {1'b0, a} + {1'b0, b};
        cpu_pkg::ADC: wide = {1'b0, a} + {1'b0, b} + {8'd0, flags.carry};
        cpu_pkg::SBB: wide = {1'b0, a} - {1'b0, b} - {8'd0, flags.carry};
        cpu_pkg::ANA: wide = {1'b0, a & b};
        cpu_pkg::XRA: wide = {1'b0, a ^ b};
        cpu_pkg::ORA: wide = {1'b0, a | b};
        default:      wide = {1'b0, a} - {1'b0, b};  // SUB and CMP
      endcase
      result = (op == cpu_pkg::CMP) ? a : wide[7:0];
      cy = wide[8];
    end
  end

  // CMP sets flags from the difference, not the result
  assign chk = (!is_rot && !is_incdec && op == cpu_pkg::CMP) ? wide[7:0] : result;

  always_comb begin
    flags_next.carry = cy;
    flags_next.zero = is_rot ? flags.zero : (chk == 8'd0);
    flags_next.sign = is_rot ? flags.sign : chk[7];
    flags_next.parity = is_rot ? flags.parity : ~^chk;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      flags <= '0;
    end else if (flag_we) begin
      flags <= flags_next;
    end
  end

endmodule

// File: src/reg_file.sv
module reg_file (
  input  logic clk,
  input  logic rst,
  input  logic we,
  input  cpu_pkg::reg_sel_t sel,
  input  cpu_pkg::word_t wdata,
  output cpu_pkg::word_t rdata,
  output cpu_pkg::word_t acc
);

  cpu_pkg::word_t regs [cpu_pkg::num_regs];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < cpu_pkg::num_regs; i++) begin
        regs[i] <= '0;
      end
    end else if (we && sel != cpu_pkg::reg_mem) begin
      regs[sel] <= wdata;
    end
  end

  // M reads back as A
  assign rdata = (sel == cpu_pkg::reg_mem) ? regs[cpu_pkg::reg_acc] : regs[sel];
  assign acc = regs[cpu_pkg::reg_acc];

endmodule

// File: src/addr_stack.sv
module addr_stack (
  input  logic clk,
  input  logic rst,
  input  logic pc_inc,
  input  logic we_lo,
  input  logic we_hi,
  input  logic push,
  input  logic pop,
  input  cpu_pkg::word_t wdata,
  output cpu_pkg::addr_t pc
);

  localparam cpu_pkg::sp_t sp_top = cpu_pkg::sp_t'(cpu_pkg::stack_depth - 1);

  cpu_pkg::addr_t entries [cpu_pkg::stack_depth];
  cpu_pkg::sp_t sp;

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < cpu_pkg::stack_depth; i++) begin
        entries[i] <= '0;
      end
      sp <= '0;
    end else begin
      if (we_lo) begin
        entries[sp][7:0] <= wdata;
      end else if (we_hi) begin
        entries[sp][13:8] <= wdata[5:0];
      end else if (pc_inc) begin
        entries[sp] <= entries[sp] + 14'd1;
      end

      // Saturates, so a call past the top reuses the top entry
      if (push && sp != sp_top) begin
        sp <= sp + 3'd1;
      end else if (pop && sp != '0) begin
        sp <= sp - 3'd1;
      end
    end
  end

  assign pc = entries[sp];  // Current entry is the PC

endmodule

// File: src/datapath.sv
module datapath (
  input  logic clk,
  input  logic rst,
  input  cpu_pkg::ctrl_t ctrl,
  input  cpu_pkg::word_t data_in,
  output cpu_pkg::flags_t flags,
  output cpu_pkg::word_t instr,
  output cpu_pkg::word_t data_out
);

  cpu_pkg::word_t ir;
  cpu_pkg::word_t tmp_a;
  cpu_pkg::word_t tmp_b;
  cpu_pkg::word_t bus_int;
  cpu_pkg::word_t acc;
  cpu_pkg::word_t rf_rdata;
  cpu_pkg::word_t alu_result;
  cpu_pkg::addr_t pc;
  logic is_incdec;

  always_ff @(posedge clk) begin
    if (rst) begin
      ir <= '0;
    end else if (ctrl.ir_we) begin
      ir <= data_in;
    end
  end

  // Fetched byte is visible to the decoder during its own T3
  assign instr = ctrl.ir_we ? data_in : ir;

  always_ff @(posedge clk) begin
    if (ctrl.a_we) tmp_a <= ctrl.a_from_acc ? acc : bus_int;
    if (ctrl.b_we) tmp_b <= bus_int;
  end

  always_comb begin
    case (ctrl.bus_src)
      cpu_pkg::NONE:    bus_int = '0;
      cpu_pkg::PC_LO:   bus_int = pc[7:0];
      cpu_pkg::PC_HI:   bus_int = {2'b00, pc[13:8]};
      cpu_pkg::REG:     bus_int = rf_rdata;
      cpu_pkg::ALU:     bus_int = alu_result;
      cpu_pkg::TMP_A:   bus_int = tmp_a;
      cpu_pkg::TMP_B:   bus_int = tmp_b;
      cpu_pkg::DATA_IN: bus_int = data_in;
      default:          bus_int = '0;
    endcase
    // T2 carries the cycle type on top
    if (ctrl.bus_src == cpu_pkg::PC_HI || ctrl.cycle_type == cpu_pkg::PCC) begin
      bus_int[7:6] = ctrl.cycle_type;
    end
  end

  assign data_out = bus_int;

  assign is_incdec = !ctrl.alu_en && !ctrl.alu_is_rot;

  alu alu_i (
    .clk        (clk),
    .rst        (rst),
    .a          (tmp_a),
    .b          (tmp_b),
    .op         (ctrl.alu_op),
    .rot_op     (ctrl.rot_op),
    .is_rot     (ctrl.alu_is_rot),
    .is_incdec  (is_incdec),
    .is_dec     (ir[0]),  // DCR has bit 0 set
    .flag_we    (ctrl.flag_we),
    .result     (alu_result),
    .flags      (flags)
  );

  reg_file reg_file_i (
    .clk   (clk),
    .rst   (rst),
    .we    (ctrl.rf_we),
    .sel   (ctrl.rf_sel),
    .wdata (bus_int),
    .rdata (rf_rdata),
    .acc   (acc)
  );

  addr_stack addr_stack_i (
    .clk    (clk),
    .rst    (rst),
    .pc_inc (ctrl.pc_inc),
    .we_lo  (ctrl.stack_we_lo),
    .we_hi  (ctrl.stack_we_hi),
    .push   (ctrl.sp_push),
    .pop    (ctrl.sp_pop),
    .wdata  (bus_int),
    .pc     (pc)
  );

endmodule

// File: src/control_fsm.sv
module control_fsm (
  input  logic clk,
  input  logic rst,
  input  cpu_pkg::word_t instr,
  input  cpu_pkg::flags_t flags,
  output cpu_pkg::ctrl_t ctrl,
  output cpu_pkg::state_t state,
  output logic sync
);

  cpu_pkg::cycle_t cycle;
  cpu_pkg::cycle_t cycle_next;
  cpu_pkg::state_t state_next;
  cpu_pkg::reg_sel_t src_reg;
  cpu_pkg::reg_sel_t dst_reg;
  logic is_hlt, is_mov, is_alu_r, is_mvi, is_inr, is_dcr, is_alu_i;
  logic is_rot, is_ret, is_jmp, is_jc, is_cal, is_out;
  logic cond_flag;
  logic jump_taken;
  logic needs_cycle2;
  logic needs_t4;

  assign src_reg = instr[2:0];
  assign dst_reg = instr[5:3];

  // Instruction decode, IR content or the byte being fetched in T3
  assign is_hlt = ((instr & cpu_pkg::mask_hlt) == cpu_pkg::op_hlt) ||
                  (instr == cpu_pkg::op_hlt_alt);
  assign is_mov = ((instr & cpu_pkg::mask_two_fields) == cpu_pkg::op_mov) && !is_hlt;
  assign is_alu_r = (instr & cpu_pkg::mask_two_fields) == cpu_pkg::op_alu_r;
  assign is_mvi = (instr & cpu_pkg::mask_dst_field) == cpu_pkg::op_mvi;
  assign is_inr = ((instr & cpu_pkg::mask_dst_field) == cpu_pkg::op_inr) && !is_hlt;
  assign is_dcr = ((instr & cpu_pkg::mask_dst_field) == cpu_pkg::op_dcr) && !is_hlt;
  assign is_alu_i = (instr & cpu_pkg::mask_dst_field) == cpu_pkg::op_alu_i;
  assign is_rot = (instr & cpu_pkg::mask_cc_field) == cpu_pkg::op_rot;
  assign is_ret = (instr & cpu_pkg::mask_dst_field) == cpu_pkg::op_ret;
  assign is_jmp = (instr & cpu_pkg::mask_dst_field) == cpu_pkg::op_jmp;
  assign is_cal = (instr & cpu_pkg::mask_dst_field) == cpu_pkg::op_cal;
  assign is_jc = ((instr & cpu_pkg::mask_cc_field) == cpu_pkg::op_jfc) ||
                 ((instr & cpu_pkg::mask_cc_field) == cpu_pkg::op_jtc);
  assign is_out = ((instr & cpu_pkg::mask_out) == cpu_pkg::op_out) && (instr[5:4] != 2'b00);

  assign needs_cycle2 = is_mvi || is_alu_i || is_out || is_jmp || is_jc || is_cal;
  assign needs_t4 = is_mov || is_alu_r || is_inr || is_dcr || is_rot || is_ret;

  always_comb begin
    case (instr[4:3])
      2'b00: cond_flag = flags.carry;
      2'b01: cond_flag = flags.zero;
      2'b10: cond_flag = flags.sign;
      default: cond_flag = flags.parity;
    endcase
  end

  // Bit 5 set means jump on true
  assign jump_taken = is_jmp || (is_jc && (cond_flag == instr[5]));

  assign sync = (state == cpu_pkg::T1) || (state == cpu_pkg::T2);

  always_comb begin
    ctrl = '0;
    state_next = state;
    cycle_next = cycle;
    case (state)
      cpu_pkg::T1: begin
        state_next = cpu_pkg::T2;
        if (cycle == cpu_pkg::CYCLE2 && is_out) begin
          ctrl.bus_src = cpu_pkg::REG;  // Accumulator goes out in T1
          ctrl.rf_sel = cpu_pkg::reg_acc;
        end else begin
          ctrl.bus_src = cpu_pkg::PC_LO;
        end
      end
      cpu_pkg::T2: begin
        state_next = cpu_pkg::T3;
        if (cycle == cpu_pkg::CYCLE2 && is_out) begin
          ctrl.bus_src = cpu_pkg::TMP_B;  // B still holds the opcode
          ctrl.cycle_type = cpu_pkg::PCC;
        end else begin
          ctrl.bus_src = cpu_pkg::PC_HI;
          ctrl.pc_inc = 1'b1;  // High byte already on the bus
          ctrl.cycle_type = (cycle == cpu_pkg::CYCLE1) ? cpu_pkg::PCI : cpu_pkg::PCR;
        end
      end
      cpu_pkg::T3: begin
        state_next = cpu_pkg::T1;
        cycle_next = cpu_pkg::CYCLE1;
        case (cycle)
          cpu_pkg::CYCLE1: begin
            ctrl.bus_src = cpu_pkg::DATA_IN;
            ctrl.ir_we = 1'b1;
            ctrl.b_we = 1'b1;
            if (is_hlt) begin
              state_next = cpu_pkg::STOPPED;
            end else if (needs_cycle2) begin
              cycle_next = cpu_pkg::CYCLE2;
            end else if (needs_t4) begin
              state_next = cpu_pkg::T4;
              cycle_next = cpu_pkg::CYCLE1;
            end
          end
          cpu_pkg::CYCLE2: begin
            if (!is_out) begin
              ctrl.bus_src = cpu_pkg::DATA_IN;  // Immediate or low target byte
              ctrl.b_we = 1'b1;
            end
            if (is_mvi || is_alu_i) begin
              state_next = cpu_pkg::T4;
              cycle_next = cpu_pkg::CYCLE2;
            end else if (is_jmp || is_jc || is_cal) begin
              cycle_next = cpu_pkg::CYCLE3;
            end
          end
          default: begin
            ctrl.bus_src = cpu_pkg::DATA_IN;  // High target byte
            ctrl.a_we = 1'b1;
            ctrl.sp_push = is_cal;
            if (is_cal || jump_taken) begin
              state_next = cpu_pkg::T4;
              cycle_next = cpu_pkg::CYCLE3;
            end
          end
        endcase
      end
      cpu_pkg::T4: begin
        state_next = cpu_pkg::T5;
        case (cycle)
          cpu_pkg::CYCLE1: begin
            if (is_mov || is_alu_r) begin
              ctrl.bus_src = cpu_pkg::REG;
              ctrl.rf_sel = src_reg;
              ctrl.b_we = 1'b1;
            end
            if (is_inr || is_dcr) begin
              ctrl.bus_src = cpu_pkg::REG;
              ctrl.rf_sel = dst_reg;
              ctrl.a_we = 1'b1;
            end
            ctrl.a_we = ctrl.a_we || is_alu_r || is_rot;
            ctrl.a_from_acc = is_alu_r || is_rot;
            ctrl.sp_pop = is_ret;
          end
          cpu_pkg::CYCLE2: begin
            ctrl.a_we = is_alu_i;
            ctrl.a_from_acc = is_alu_i;
          end
          default: begin
            ctrl.bus_src = cpu_pkg::TMP_A;
            ctrl.stack_we_hi = 1'b1;
          end
        endcase
      end
      cpu_pkg::T5: begin
        state_next = cpu_pkg::T1;
        cycle_next = cpu_pkg::CYCLE1;
        if (cycle == cpu_pkg::CYCLE3) begin
          ctrl.bus_src = cpu_pkg::TMP_B;
          ctrl.stack_we_lo = 1'b1;
        end else if (is_mov || is_mvi) begin
          ctrl.bus_src = cpu_pkg::TMP_B;
          ctrl.rf_we = 1'b1;
          ctrl.rf_sel = dst_reg;
        end else if (is_alu_r || is_alu_i || is_rot) begin
          ctrl.bus_src = cpu_pkg::ALU;
          ctrl.alu_en = !is_rot;
          ctrl.alu_is_rot = is_rot;
          ctrl.alu_op = cpu_pkg::alu_op_t'(instr[5:3]);
          ctrl.rot_op = cpu_pkg::rot_op_t'(instr[4:3]);
          ctrl.flag_we = 1'b1;
          ctrl.rf_we = 1'b1;
          ctrl.rf_sel = cpu_pkg::reg_acc;
        end else if (is_inr || is_dcr) begin
          ctrl.bus_src = cpu_pkg::ALU;  // Increment or decrement of A
          ctrl.flag_we = 1'b1;
          ctrl.rf_we = 1'b1;
          ctrl.rf_sel = dst_reg;
        end
      end
      cpu_pkg::STOPPED: begin
        state_next = cpu_pkg::STOPPED;  // Only reset leaves this
      end
      default: begin
        state_next = cpu_pkg::T1;
        cycle_next = cpu_pkg::CYCLE1;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= cpu_pkg::T1;
      cycle <= cpu_pkg::CYCLE1;
    end else begin
      state <= state_next;
      cycle <= cycle_next;
    end
  end

endmodule

// File: src/cpu8_top.sv
module cpu8_top (
  input  logic clk,
  input  logic rst,
  input  cpu_pkg::word_t data_in,
  output cpu_pkg::bus_out_t bus
);

  cpu_pkg::ctrl_t ctrl;
  cpu_pkg::word_t instr;
  cpu_pkg::word_t data_out;
  cpu_pkg::flags_t flags;
  cpu_pkg::state_t state;
  logic sync;

  control_fsm control_fsm_i (
    .clk   (clk),
    .rst   (rst),
    .instr (instr),
    .flags (flags),
    .ctrl  (ctrl),
    .state (state),
    .sync  (sync)
  );

  datapath datapath_i (
    .clk      (clk),
    .rst      (rst),
    .ctrl     (ctrl),
    .data_in  (data_in),
    .flags    (flags),
    .instr    (instr),
    .data_out (data_out)
  );

  assign bus = '{data: data_out, state: state, sync: sync};

endmodule

// File: tests/tb_clock.sv
module tb_clock (
  output logic clk
);

  initial begin
    clk = 1'b0;
  end

  always #4 clk = ~clk;  // Period 8

endmodule

// File: tests/cpu8_props.sv
module cpu8_props (
  input logic clk,
  input logic rst,
  input cpu_pkg::bus_out_t bus
);

  // Address bytes only go out in T1 and T2
  sync_in_t1_t2: assert property (@(posedge clk) disable iff (rst)
    bus.sync |-> (bus.state == cpu_pkg::T1 || bus.state == cpu_pkg::T2))
    else $error("sync high outside T1 and T2");

  state_legal: assert property (@(posedge clk) disable iff (rst)
    bus.state inside {cpu_pkg::T1, cpu_pkg::T2, cpu_pkg::T3, cpu_pkg::T4, cpu_pkg::T5,
                      cpu_pkg::STOPPED})
    else $error("undefined state code on the bus");

  stopped_holds: assert property (@(posedge clk) disable iff (rst)
    bus.state == cpu_pkg::STOPPED |=> bus.state == cpu_pkg::STOPPED && !bus.sync)
    else $error("core left STOPPED or raised sync while halted");

  // Only PCI, PCR and PCC remain in this core
  cycle_type_kept: assert property (@(posedge clk) disable iff (rst)
    (bus.sync && bus.state == cpu_pkg::T2) |->
      bus.data[7:6] inside {cpu_pkg::PCI, cpu_pkg::PCR, cpu_pkg::PCC})
    else $error("unexpected cycle type in T2");

endmodule

bind cpu8_top cpu8_props cpu8_props_i (.clk(clk), .rst(rst), .bus(bus));

// File: tests/tb_top.sv
module tb_top;

  localparam int max_cycles = 20000;  // About 50 runs of at most 200 cycles, doubled

  logic clk;
  logic rst;
  cpu_pkg::word_t data_in;
  cpu_pkg::bus_out_t bus;

  cpu_pkg::word_t mem [256];
  cpu_pkg::word_t addr_lo;
  cpu_pkg::word_t outs [$];      // Bytes seen in PCC cycles
  cpu_pkg::word_t exp_outs [$];
  cpu_pkg::addr_t fetches [$];   // PCI addresses
  cpu_pkg::addr_t reads [$];     // PCR addresses
  int asm_pc;
  int cycles = 0;
  logic [31:0] lfsr;

  tb_clock tb_clock_i (.clk(clk));

  cpu8_top cpu8_top_i (.clk(clk), .rst(rst), .data_in(data_in), .bus(bus));

  // Program memory answers in T3 and the monitor logs every bus cycle
  always @(posedge clk) begin
    if (!rst && bus.sync) begin
      if (bus.state == cpu_pkg::T1) begin
        addr_lo <= bus.data;
      end else if (bus.state == cpu_pkg::T2) begin
        data_in <= mem[addr_lo];
        case (bus.data[7:6])
          cpu_pkg::PCI: fetches.push_back({bus.data[5:0], addr_lo});
          cpu_pkg::PCR: reads.push_back({bus.data[5:0], addr_lo});
          default: outs.push_back(addr_lo);  // OUT puts the accumulator in T1
        endcase
      end
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= max_cycles) begin
      $display("Simulation timed out after %0d cycles", cycles);
      $display("ERRORS FOUND");
      $fatal(1, "timeout");
    end
  end

  task automatic check(input string name, input logic [31:0] expected,
                       input logic [31:0] actual);
    if (expected !== actual) begin
      $display("ERROR %s expected %0h actual %0h", name, expected, actual);
      $display("ERRORS FOUND");
      $fatal(1, "check failed");
    end
  endtask

  // Fibonacci LFSR with taps 32 22 2 1
  function automatic logic [7:0] rand_bits(input int n);
    logic [7:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
      v = {v[6:0], lfsr[0]};
    end
    return v;
  endfunction

  task automatic new_prog();
    for (int i = 0; i < 256; i++) begin
      mem[i] = 8'(i) ^ 8'h5c;
    end
    asm_pc = 0;
    exp_outs.delete();
  endtask

  task automatic emit(input cpu_pkg::word_t b);
    mem[asm_pc] = b;
    asm_pc++;
  endtask

  task automatic emit_mvi(input int r, input cpu_pkg::word_t v);
    emit(cpu_pkg::op_mvi | 8'(r << 3));
    emit(v);
  endtask

  task automatic emit_jump(input cpu_pkg::word_t op, input int target);
    emit(op);
    emit(8'(target));
    emit(8'(target >> 8));
  endtask

  task automatic emit_out();
    emit(cpu_pkg::op_out | 8'b00_010_000);
  endtask

  // Leaves carry = cin with Z=1, S=0, P=1
  task automatic emit_preset(input logic cin);
    emit_mvi(0, cin ? 8'hff : 8'h00);
    emit(cpu_pkg::op_alu_i);
    emit(cin ? 8'h01 : 8'h00);
  endtask

  // OUT of 1 when flag cc is set, else 0
  task automatic emit_probe(input int cc);
    int p;
    p = asm_pc;
    emit_jump(cpu_pkg::op_jtc | 8'(cc << 3), p + 9);
    emit_mvi(0, 8'h00);
    emit_out();
    emit_jump(cpu_pkg::op_jmp, p + 12);
    emit_mvi(0, 8'h01);
    emit_out();
  endtask

  task automatic run_prog();
    @(posedge clk);
    rst <= 1'b1;
    repeat (2) @(posedge clk);
    outs.delete();
    fetches.delete();
    reads.delete();
    repeat (14) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    while (bus.state != cpu_pkg::STOPPED) begin
      @(negedge clk);
    end
  endtask

  task automatic check_outs(input string name);
    check({name, " out count"}, exp_outs.size(), outs.size());
    foreach (exp_outs[i]) begin
      check(name, exp_outs[i], outs[i]);
    end
  endtask

  task automatic test_fetch();
    int exp_f [4] = '{0, 2, 3, 4};
    new_prog();
    emit_mvi(0, 8'h5a);
    emit(cpu_pkg::op_mov | 8'b00_001_000);  // MOV B,A
    emit(cpu_pkg::op_inr | 8'b00_001_000);  // INR B
    emit(cpu_pkg::op_hlt);
    run_prog();
    check("fetch count", 4, fetches.size());
    foreach (exp_f[i]) begin
      check("fetch addr", exp_f[i], fetches[i]);
    end
    check("read count", 1, reads.size());
    check("read addr", 1, reads[0]);
  endtask

  task automatic test_moves();
    cpu_pkg::word_t vals [7];
    new_prog();
    for (int r = 1; r < 7; r++) begin
      vals[r] = rand_bits(8);
      emit_mvi(r, vals[r]);
    end
    for (int r = 1; r < 7; r++) begin
      emit(cpu_pkg::op_mov | 8'(r));  // MOV A,r
      emit_out();
      exp_outs.push_back(vals[r]);
    end
    vals[0] = rand_bits(8);
    emit_mvi(1, vals[0]);
    for (int r = 2; r < 7; r++) begin
      emit(cpu_pkg::op_mov | 8'(r << 3) | 8'(r - 1));  // Pass it along to L
    end
    emit(cpu_pkg::op_mov | 8'd6);
    emit_out();
    exp_outs.push_back(vals[0]);
    emit(cpu_pkg::op_hlt);
    run_prog();
    check_outs("moves");
  endtask

  // kind 0 ALU register, 1 ALU immediate, 2 INR, 3 DCR, 4 rotate
  task automatic test_unit(input string name, input int kind, input int op);
    cpu_pkg::word_t x, y, r;
    logic cin, c, z, s, p;
    int d;
    x = rand_bits(8);
    y = rand_bits(8);
    cin = rand_bits(1) != 0;
    new_prog();
    emit_preset(cin);
    c = cin;
    z = 1'b1;
    s = 1'b0;
    p = 1'b1;
    case (kind)
      0, 1: begin
        emit_mvi(0, x);
        if (kind == 0) begin
          emit_mvi(1, y);
          emit(cpu_pkg::op_alu_r | 8'(op << 3) | 8'd1);
        end else begin
          emit(cpu_pkg::op_alu_i | 8'(op << 3));
          emit(y);
        end
        case (op)
          0: d = x + y;
          1: d = x + y + cin;
          3: d = x - y - cin;
          4: d = x & y;
          5: d = x ^ y;
          6: d = x | y;
          default: d = x - y;
        endcase
        c = (d > 255) || (d < 0);  // Borrow when negative
        r = (op == 7) ? x : 8'(d);
        z = 8'(d) == 8'd0;
        s = d[7];
        p = ~^d[7:0];
      end
      2, 3: begin
        emit_mvi(2, x);
        emit((kind == 2 ? cpu_pkg::op_inr : cpu_pkg::op_dcr) | 8'b00_010_000);
        emit(cpu_pkg::op_mov | 8'd2);  // MOV A,C
        r = (kind == 2) ? x + 8'd1 : x - 8'd1;
        z = r == 8'd0;
        s = r[7];
        p = ~^r;
      end
      default: begin
        emit_mvi(0, x);
        emit(cpu_pkg::op_rot | 8'(op << 3));
        case (op)
          0: r = (x << 1) | (x >> 7);
          1: r = (x >> 1) | (x << 7);
          2: r = (x << 1) | 8'(cin);
          default: r = (x >> 1) | {cin, 7'd0};
        endcase
        c = (op % 2 == 0) ? x[7] : x[0];  // Bit shifted out
      end
    endcase
    emit_out();
    for (int cc = 0; cc < 4; cc++) begin
      emit_probe(cc);
    end
    emit(cpu_pkg::op_hlt);
    exp_outs.push_back(r);
    exp_outs.push_back({7'd0, c});
    exp_outs.push_back({7'd0, z});
    exp_outs.push_back({7'd0, s});
    exp_outs.push_back({7'd0, p});
    run_prog();
    check_outs(name);
  endtask

  task automatic test_cond(input int cc, input logic sense, input logic cin);
    logic flag;
    new_prog();
    emit_preset(cin);
    emit_jump((sense ? cpu_pkg::op_jtc : cpu_pkg::op_jfc) | 8'(cc << 3), 'h20);
    emit_mvi(0, 8'h0f);
    emit_out();
    emit(cpu_pkg::op_hlt);
    asm_pc = 'h20;
    emit_mvi(0, 8'hf0);
    emit_out();
    emit(cpu_pkg::op_hlt);
    flag = (cc == 0) ? cin : (cc != 2);
    exp_outs.push_back((flag == sense) ? 8'hf0 : 8'h0f);
    run_prog();
    check_outs($sformatf("cond cc%0d sense%0d cin%0d", cc, sense, cin));
  endtask

  // Three nested calls where each level outputs after its callee returns
  task automatic test_calls();
    int addrs [4] = '{'h10, 'h40, 'h50, 'h60};
    int exp_f [16] = '{'h00, 'h10, 'h40, 'h50, 'h60, 'h62, 'h63, 'h53,
                       'h55, 'h56, 'h43, 'h45, 'h46, 'h13, 'h15, 'h16};
    new_prog();
    emit_jump(cpu_pkg::op_jmp, 'h10);
    emit_mvi(0, 8'hee);
    emit_out();
    emit(cpu_pkg::op_hlt);
    for (int i = 0; i < 4; i++) begin
      asm_pc = addrs[i];
      if (i < 3) begin
        emit_jump(cpu_pkg::op_cal, addrs[i + 1]);
      end
      emit_mvi(0, 8'(i + 1) * 8'h11);
      emit_out();
      emit(i == 0 ? cpu_pkg::op_hlt : cpu_pkg::op_ret);
    end
    for (int i = 4; i > 0; i--) begin
      exp_outs.push_back(8'(i) * 8'h11);
    end
    run_prog();
    check_outs("calls");
    check("calls fetch count", 16, fetches.size());
    foreach (exp_f[i]) begin
      check("calls fetch addr", exp_f[i], fetches[i]);
    end
  endtask

  task automatic test_halt();
    new_prog();
    emit(cpu_pkg::op_hlt_alt);
    run_prog();
    check("halt fetch count", 1, fetches.size());
    repeat (50) begin
      @(negedge clk);
      check("halt sync", 0, bus.sync);
      check("halt state", cpu_pkg::STOPPED, bus.state);
    end
  endtask

  initial begin
    rst = 1'b1;
    data_in = '0;
    lfsr = 32'hb5e7_3cbd;
    test_fetch();
    test_moves();
    for (int op = 0; op < 8; op++) begin
      test_unit($sformatf("alu reg op%0d", op), 0, op);
      test_unit($sformatf("alu imm op%0d", op), 1, op);
    end
    for (int rep = 0; rep < 2; rep++) begin
      test_unit("inr", 2, 0);
      test_unit("dcr", 3, 0);
      for (int op = 0; op < 4; op++) begin
        test_unit($sformatf("rotate op%0d", op), 4, op);
      end
    end
    for (int cc = 0; cc < 4; cc++) begin
      for (int k = 0; k < 4; k++) begin
        test_cond(cc, k[0], k[1]);
      end
    end
    test_calls();
    test_halt();
    $display("NO ERRORS");
    $finish;
  end

endmodule

// File: files.f
src/cpu_pkg.sv
src/alu.sv
src/reg_file.sv
src/addr_stack.sv
src/datapath.sv
src/control_fsm.sv
src/cpu8_top.sv
tests/tb_clock.sv
tests/cpu8_props.sv
tests/tb_top.sv

// File: Bender.yml
package:
  name: cpu8

sources:
  - src/cpu_pkg.sv
  - src/alu.sv
  - src/reg_file.sv
  - src/addr_stack.sv
  - src/datapath.sv
  - src/control_fsm.sv
  - src/cpu8_top.sv
  - target: test
    files:
      - tests/tb_clock.sv
      - tests/cpu8_props.sv
      - tests/tb_top.sv
